/* design/mlaccel_isa_pkg.sv */
// Instruction fields, opcodes, operation classes and port slots of the compute unit.
`default_nettype none

package mlaccel_isa_pkg;

	localparam int insn_w   = 32;
	localparam int maddr_w  = 17;    // bits 31:15.
	localparam int caddr_w  = 9;     // bits 14:6, also the store shift.
	localparam int opcode_w = 6;     // bits 5:0.

	typedef enum logic [opcode_w-1:0] {
		opc_load_coeff0 = 6'd5,
		opc_load_coeff1 = 6'd6,
		opc_set_vbp     = 6'd8,
		opc_add_vbp     = 6'd9,
		opc_set_cbp     = 6'd14,
		opc_add_cbp     = 6'd15,
		opc_store       = 6'd16,
		opc_store0      = 6'd17,
		opc_store1      = 6'd18,
		opc_relu        = 6'd20,
		opc_relu0       = 6'd21,
		opc_relu1       = 6'd22,
		opc_ldset       = 6'd28,
		opc_ldset0      = 6'd29,
		opc_ldset1      = 6'd30,
		opc_macc        = 6'd40,
		opc_maccz       = 6'd42
	} mlaccel_opcode_e;

	// decoded class, the modifier bits travel next to it.
	typedef enum logic [3:0] {
		op_nop,
		op_set_vbp,
		op_set_cbp,
		op_load_coeff,
		op_macc,
		op_ldset,
		op_store
	} mlaccel_op_e;

	// slot k owns the memory port k+1 cycles after the instruction leaves stage 1.
	localparam int slot_read_early = 0;
	localparam int slot_read_late  = 4;
	localparam int slot_write      = 9;
	localparam int resv_depth      = 10;

endpackage

`default_nettype wire

/* design/mlaccel_data_pkg.sv */
// Datapath widths, lane layout and latencies of the compute unit.
`default_nettype none

package mlaccel_data_pkg;

	localparam int word_w     = 64;    // one memory word.
	localparam int mem_addr_w = 16;
	localparam int lanes      = 8;
	localparam int lane_w     = 8;
	localparam int coeff_rows = 512;
	localparam int coeff_w    = 128;   // two memory words per row.
	localparam int acc_w      = 32;
	localparam int sum_w      = 20;    // eight 16-bit products plus growth.
	localparam int mul_latency = 3;
	localparam int mem_latency = 3;    // read data follows mem_ren by this many cycles.

endpackage

`default_nettype wire

/* design/mlaccel_control.sv */
// Command intake, decode, memory port interlock and instruction pipeline of the compute unit.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_control (
	input  logic clock,
	input  logic reset,
	input  logic cmd_valid,
	input  logic [mlaccel_isa_pkg::insn_w-1:0] cmd_insn,
	output logic cmd_ready,
	output logic busy,
	output logic s1_go,
	output logic s3_valid,
	output logic s4_valid,
	output logic s8_valid,
	output mlaccel_isa_pkg::mlaccel_op_e s1_op,
	output logic [2:0] s1_mod,
	output logic [mlaccel_isa_pkg::maddr_w-1:0] s1_maddr,
	output logic [mlaccel_isa_pkg::caddr_w-1:0] s1_caddr,
	output mlaccel_isa_pkg::mlaccel_op_e s3_op,
	output logic [2:0] s3_mod,
	output logic [mlaccel_isa_pkg::maddr_w-1:0] s3_maddr,
	output logic [mlaccel_isa_pkg::caddr_w-1:0] s3_caddr,
	output mlaccel_isa_pkg::mlaccel_op_e s4_op,
	output logic [2:0] s4_mod,
	output logic [mlaccel_isa_pkg::maddr_w-1:0] s4_maddr,
	output logic [mlaccel_isa_pkg::caddr_w-1:0] s4_caddr,
	output mlaccel_isa_pkg::mlaccel_op_e s8_op,
	output logic [2:0] s8_mod,
	output logic [mlaccel_isa_pkg::maddr_w-1:0] s8_maddr,
	output logic [mlaccel_isa_pkg::caddr_w-1:0] s8_caddr
);
	import mlaccel_isa_pkg::*;

	logic s1_valid;
	logic [insn_w-1:0] s1_insn;
	logic [opcode_w-1:0] s1_opc;
	logic s1_stall;
	mlaccel_op_e dec_op;
	logic [2:0] dec_mod;
	logic [resv_depth-1:0] resv;         // bit k set means the port is taken k+1 cycles ahead.
	logic [resv_depth-1:0] resv_mask;

	// index k holds the instruction k cycles after it left stage 1.
	logic [9:1] pipe_valid;
	mlaccel_op_e pipe_op [1:8];
	logic [2:0] pipe_mod [1:8];
	logic [maddr_w-1:0] pipe_maddr [1:8];
	logic [caddr_w-1:0] pipe_caddr [1:8];

	assign s1_opc   = s1_insn[opcode_w-1:0];
	assign s1_maddr = s1_insn[insn_w-1 -: maddr_w];
	assign s1_caddr = s1_insn[opcode_w +: caddr_w];

	always_comb begin
		dec_op = op_nop;
		dec_mod = 3'b000;
		resv_mask = '0;
		case (mlaccel_opcode_e'(s1_opc))
			opc_set_vbp, opc_add_vbp: begin
				dec_op = op_set_vbp;
				dec_mod = {2'b00, s1_opc[0]};       // add to pointer.
			end
			opc_set_cbp, opc_add_cbp: begin
				dec_op = op_set_cbp;
				dec_mod = {2'b00, s1_opc[0]};
			end
			opc_load_coeff0, opc_load_coeff1: begin
				dec_op = op_load_coeff;
				dec_mod = {1'b0, s1_opc[1], 1'b0};  // high half.
				resv_mask[slot_read_early] = 1'b1;
			end
			opc_macc, opc_maccz: begin
				dec_op = op_macc;
				dec_mod = {1'b0, s1_opc[1], 1'b0};  // clear first.
				resv_mask[slot_read_early] = 1'b1;
			end
			opc_ldset, opc_ldset0, opc_ldset1: begin
				dec_op = op_ldset;
				dec_mod = {1'b0, s1_opc[0], s1_opc[1]};
				resv_mask[slot_read_late] = 1'b1;
			end
			opc_store, opc_store0, opc_store1, opc_relu, opc_relu0, opc_relu1: begin
				// opcode bits 0 and 1 trade places in mod.
				dec_op = op_store;
				dec_mod = {s1_opc[2], s1_opc[0], s1_opc[1]};
				resv_mask[slot_write] = 1'b1;
			end
			default: dec_op = op_nop;
		endcase
		if (!s1_valid)
			resv_mask = '0;
	end

	assign s1_stall  = |(resv & resv_mask);
	assign s1_go     = s1_valid && !s1_stall;
	assign cmd_ready = !s1_stall;
	assign s1_op     = dec_op;
	assign s1_mod    = dec_mod;

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
			resv <= '0;
			pipe_valid <= '0;
		end else begin
			if (!s1_stall)
				s1_valid <= cmd_valid;
			resv <= (resv | (s1_go ? resv_mask : '0)) >> 1;
			pipe_valid <= {pipe_valid[8:1], s1_go};
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_valid && cmd_ready)
			s1_insn <= cmd_insn;
		pipe_op[1] <= dec_op;
		pipe_mod[1] <= dec_mod;
		pipe_maddr[1] <= s1_maddr;
		pipe_caddr[1] <= s1_caddr;
		for (int k = 2; k <= 8; k++) begin
			pipe_op[k] <= pipe_op[k-1];
			pipe_mod[k] <= pipe_mod[k-1];
			pipe_maddr[k] <= pipe_maddr[k-1];
			pipe_caddr[k] <= pipe_caddr[k-1];
		end
	end

	assign s3_valid = pipe_valid[3];
	assign s3_op    = pipe_op[3];
	assign s3_mod   = pipe_mod[3];
	assign s3_maddr = pipe_maddr[3];
	assign s3_caddr = pipe_caddr[3];

	assign s4_valid = pipe_valid[4];
	assign s4_op    = pipe_op[4];
	assign s4_mod   = pipe_mod[4];
	assign s4_maddr = pipe_maddr[4];
	assign s4_caddr = pipe_caddr[4];

	assign s8_valid = pipe_valid[8];
	assign s8_op    = pipe_op[8];
	assign s8_mod   = pipe_mod[8];
	assign s8_maddr = pipe_maddr[8];
	assign s8_caddr = pipe_caddr[8];

	assign busy = s1_valid || |pipe_valid;

endmodule

`default_nettype wire

/* design/mlaccel_mem_port.sv */
// Shared memory port with the vector base pointer, both read requests and byte-lane writes.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_mem_port (
	input  logic clock,
	input  logic reset,
	input  logic s1_go,
	input  mlaccel_isa_pkg::mlaccel_op_e s1_op,
	input  logic [2:0] s1_mod,
	input  logic [mlaccel_isa_pkg::maddr_w-1:0] s1_maddr,
	input  logic s4_valid,
	input  mlaccel_isa_pkg::mlaccel_op_e s4_op,
	input  logic [mlaccel_isa_pkg::maddr_w-1:0] s4_maddr,
	input  logic [1:0] wr_en,
	input  logic [mlaccel_isa_pkg::maddr_w-1:0] wr_maddr,
	input  logic [2*mlaccel_data_pkg::lane_w-1:0] wr_data,
	output logic mem_ren,
	output logic [mlaccel_data_pkg::lanes-1:0] mem_wen,
	output logic [mlaccel_data_pkg::mem_addr_w-1:0] mem_addr,
	output logic [mlaccel_data_pkg::word_w-1:0] mem_wdata
);
	import mlaccel_isa_pkg::*;
	import mlaccel_data_pkg::*;

	logic [maddr_w-1:0] vbp;
	logic [maddr_w-1:0] vec_addr;
	logic rd_early, rd_late;
	logic [mem_addr_w-1:0] early_addr, late_addr;

	assign vec_addr = s1_maddr + vbp;    // byte-pair address, wraps at 17 bits.

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_early <= 1'b0;
			rd_late <= 1'b0;
		end else begin
			rd_early <= s1_go && (s1_op == op_macc || s1_op == op_load_coeff);
			rd_late <= s4_valid && s4_op == op_ldset;
		end
	end

	always_ff @(posedge clock) begin
		if (s1_op == op_macc)
			early_addr <= vec_addr[maddr_w-1:1];
		else
			early_addr <= s1_maddr[maddr_w-1:1];
		late_addr <= s4_maddr[maddr_w-1:1];    // ldset addresses are absolute.
		if (s1_go && s1_op == op_set_vbp)
			vbp <= s1_maddr + (s1_mod[0] ? vbp : '0);
	end

	// the interlock keeps reads and writes in separate cycles.
	always_comb begin
		if (rd_early)
			mem_addr = early_addr;
		else if (rd_late)
			mem_addr = late_addr;
		else
			mem_addr = wr_maddr[maddr_w-1:1];
	end

	assign mem_ren   = rd_early || rd_late;
	assign mem_wen   = lanes'(wr_en) << wr_maddr[0];    // odd address moves up one lane.
	assign mem_wdata = word_w'(wr_data) << (wr_maddr[0] ? lane_w : 0);

endmodule

`default_nettype wire

/* design/mlaccel_coeff_store.sv */
// Coefficient memory with its base pointer, half-row loads and the row fetch for stage 4.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_coeff_store (
	input  logic clock,
	input  logic reset,
	input  logic s3_valid,
	input  mlaccel_isa_pkg::mlaccel_op_e s3_op,
	input  logic [2:0] s3_mod,
	input  logic [mlaccel_isa_pkg::caddr_w-1:0] s3_caddr,
	input  logic [mlaccel_data_pkg::word_w-1:0] mem_rdata,
	output logic [mlaccel_data_pkg::coeff_w-1:0] coeff_row
);
	import mlaccel_isa_pkg::*;
	import mlaccel_data_pkg::*;

	logic [word_w-1:0] coeff_lo [coeff_rows];
	logic [word_w-1:0] coeff_hi [coeff_rows];
	logic [caddr_w-1:0] cbp;
	logic [caddr_w-1:0] row_idx;
	logic ld_en;
	logic ld_high;
	logic [caddr_w-1:0] ld_row;

	assign row_idx = s3_caddr + cbp;    // wraps within the 512 rows.

	always_ff @(posedge clock) begin
		if (reset)
			ld_en <= 1'b0;
		else
			ld_en <= s3_valid && s3_op == op_load_coeff;
	end

	always_ff @(posedge clock) begin
		coeff_row <= {coeff_hi[row_idx], coeff_lo[row_idx]};
		ld_high <= s3_mod[1];
		ld_row <= s3_caddr;    // loads ignore CBP.

		if (s3_valid && s3_op == op_set_cbp)
			cbp <= s3_caddr + (s3_mod[0] ? cbp : '0);

		// load data arrives in stage 4, a row read in the same cycle sees the old half.
		if (ld_en) begin
			if (ld_high)
				coeff_hi[ld_row] <= mem_rdata;
			else
				coeff_lo[ld_row] <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

/* design/mlaccel_mac_array.sv */
// Sixteen pipelined signed byte multipliers feeding two eight-lane adder trees.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_mac_array (
	input  logic clock,
	input  logic [mlaccel_data_pkg::word_w-1:0] mem_rdata,
	input  logic [mlaccel_data_pkg::coeff_w-1:0] coeff_row,
	output logic signed [mlaccel_data_pkg::sum_w-1:0] sum0,
	output logic signed [mlaccel_data_pkg::sum_w-1:0] sum1
);
	import mlaccel_data_pkg::*;

	logic signed [lane_w-1:0] vec_b [lanes];
	logic signed [lane_w-1:0] coef_b [2*lanes];
	logic signed [2*lane_w-1:0] prod [mul_latency][2*lanes];
	logic signed [sum_w-1:0] tree0, tree1;

	always_comb begin
		for (int i = 0; i < lanes; i++)
			vec_b[i] = mem_rdata[i*lane_w +: lane_w];
		for (int i = 0; i < 2*lanes; i++)
			coef_b[i] = coeff_row[i*lane_w +: lane_w];
	end

	// products 0..7 use the low half of the row and 8..15 the high half.
	always_ff @(posedge clock) begin
		for (int i = 0; i < 2*lanes; i++)
			prod[0][i] <= vec_b[i % lanes] * coef_b[i];
		for (int s = 1; s < mul_latency; s++)
			prod[s] <= prod[s-1];
	end

	always_comb begin
		tree0 = '0;
		tree1 = '0;
		for (int i = 0; i < lanes; i++) begin
			tree0 += prod[mul_latency-1][i];
			tree1 += prod[mul_latency-1][lanes+i];
		end
	end

	always_ff @(posedge clock) begin
		sum0 <= tree0;    // lines up with stage 8.
		sum1 <= tree1;
	end

endmodule

`default_nettype wire

/* design/mlaccel_accum.sv */
// Accumulator pair with MACC and LdSet updates, shifted saturation, ReLU and store requests.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_accum (
	input  logic clock,
	input  logic reset,
	input  logic s8_valid,
	input  mlaccel_isa_pkg::mlaccel_op_e s8_op,
	input  logic [2:0] s8_mod,
	input  logic [mlaccel_isa_pkg::maddr_w-1:0] s8_maddr,
	input  logic [mlaccel_isa_pkg::caddr_w-1:0] s8_caddr,
	input  logic signed [mlaccel_data_pkg::sum_w-1:0] sum0,
	input  logic signed [mlaccel_data_pkg::sum_w-1:0] sum1,
	input  logic [mlaccel_data_pkg::word_w-1:0] mem_rdata,
	output logic [1:0] wr_en,
	output logic [mlaccel_isa_pkg::maddr_w-1:0] wr_maddr,
	output logic [2*mlaccel_data_pkg::lane_w-1:0] wr_data
);
	import mlaccel_isa_pkg::*;
	import mlaccel_data_pkg::*;

	logic [acc_w-1:0] acc0, acc1;
	logic [lane_w-1:0] sat0, sat1;
	logic s9_store;
	logic [2:0] s9_mod;
	logic [maddr_w-1:0] s9_maddr;
	logic keep0, keep1;

	// arithmetic shift, then clamp to the signed byte range.
	function automatic logic [lane_w-1:0] sat_byte(
		input logic [acc_w-1:0] acc,
		input logic [caddr_w-1:0] sh
	);
		logic signed [acc_w-1:0] shifted;
		shifted = $signed(acc) >>> sh;
		if (&shifted[acc_w-1:lane_w-1] == |shifted[acc_w-1:lane_w-1])
			return shifted[lane_w-1:0];
		return shifted[acc_w-1] ? 8'h80 : 8'h7f;
	endfunction

	always_ff @(posedge clock) begin
		if (s8_valid && s8_op == op_macc) begin
			acc0 <= (s8_mod[1] ? '0 : acc0) + acc_w'(sum0);
			acc1 <= (s8_mod[1] ? '0 : acc1) + acc_w'(sum1);
		end
		if (s8_valid && s8_op == op_ldset) begin
			if (!s8_mod[0])
				acc0 <= mem_rdata[acc_w-1:0];
			if (!s8_mod[1])
				acc1 <= mem_rdata[2*acc_w-1:acc_w];
		end

		// taken from the values before this edge, so earlier updates are visible.
		sat0 <= sat_byte(acc0, s8_caddr);
		sat1 <= sat_byte(acc1, s8_caddr);
		s9_mod <= s8_mod;
		s9_maddr <= s8_maddr;

		wr_maddr <= s9_maddr;
		wr_data <= {sat1 & {lane_w{keep1}}, sat0 & {lane_w{keep0}}};
	end

	assign keep0 = !(s9_mod[2] && sat0[lane_w-1]);    // ReLU drops negative bytes.
	assign keep1 = !(s9_mod[2] && sat1[lane_w-1]);

	always_ff @(posedge clock) begin
		if (reset) begin
			s9_store <= 1'b0;
			wr_en <= 2'b00;
		end else begin
			s9_store <= s8_valid && s8_op == op_store;
			wr_en <= s9_store ? {!s9_mod[1], !s9_mod[0]} : 2'b00;
		end
	end

endmodule

`default_nettype wire

/* design/mlaccel_compute.sv */
// Top level of the compute unit, joining control, memory port, coefficients, MACs and accumulators.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_compute (
	input  logic clock,
	input  logic reset,
	input  logic cmd_valid,
	input  logic [mlaccel_isa_pkg::insn_w-1:0] cmd_insn,
	output logic cmd_ready,
	output logic busy,
	output logic mem_ren,
	output logic [mlaccel_data_pkg::lanes-1:0] mem_wen,
	output logic [mlaccel_data_pkg::mem_addr_w-1:0] mem_addr,
	output logic [mlaccel_data_pkg::word_w-1:0] mem_wdata,
	input  logic [mlaccel_data_pkg::word_w-1:0] mem_rdata
);
	import mlaccel_isa_pkg::*;
	import mlaccel_data_pkg::*;

	logic s1_go, s3_valid, s4_valid, s8_valid;
	mlaccel_op_e s1_op, s3_op, s4_op, s8_op;
	logic [2:0] s1_mod, s3_mod, s8_mod;
	logic [maddr_w-1:0] s1_maddr, s4_maddr, s8_maddr;
	logic [caddr_w-1:0] s3_caddr, s8_caddr;
	logic [coeff_w-1:0] coeff_row;
	logic signed [sum_w-1:0] sum0, sum1;
	logic [1:0] wr_en;
	logic [maddr_w-1:0] wr_maddr;
	logic [2*lane_w-1:0] wr_data;

	mlaccel_control control (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_insn  (cmd_insn),
		.cmd_ready (cmd_ready),
		.busy      (busy),
		.s1_go     (s1_go),
		.s3_valid  (s3_valid),
		.s4_valid  (s4_valid),
		.s8_valid  (s8_valid),
		.s1_op     (s1_op),
		.s1_mod    (s1_mod),
		.s1_maddr  (s1_maddr),
		.s1_caddr  (),
		.s3_op     (s3_op),
		.s3_mod    (s3_mod),
		.s3_maddr  (),
		.s3_caddr  (s3_caddr),
		.s4_op     (s4_op),
		.s4_mod    (),
		.s4_maddr  (s4_maddr),
		.s4_caddr  (),
		.s8_op     (s8_op),
		.s8_mod    (s8_mod),
		.s8_maddr  (s8_maddr),
		.s8_caddr  (s8_caddr)
	);

	mlaccel_mem_port mem_port (
		.clock     (clock),
		.reset     (reset),
		.s1_go     (s1_go),
		.s1_op     (s1_op),
		.s1_mod    (s1_mod),
		.s1_maddr  (s1_maddr),
		.s4_valid  (s4_valid),
		.s4_op     (s4_op),
		.s4_maddr  (s4_maddr),
		.wr_en     (wr_en),
		.wr_maddr  (wr_maddr),
		.wr_data   (wr_data),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	mlaccel_coeff_store coeff_store (
		.clock     (clock),
		.reset     (reset),
		.s3_valid  (s3_valid),
		.s3_op     (s3_op),
		.s3_mod    (s3_mod),
		.s3_caddr  (s3_caddr),
		.mem_rdata (mem_rdata),
		.coeff_row (coeff_row)
	);

	mlaccel_mac_array mac_array (
		.clock     (clock),
		.mem_rdata (mem_rdata),
		.coeff_row (coeff_row),
		.sum0      (sum0),
		.sum1      (sum1)
	);

	mlaccel_accum accum (
		.clock     (clock),
		.reset     (reset),
		.s8_valid  (s8_valid),
		.s8_op     (s8_op),
		.s8_mod    (s8_mod),
		.s8_maddr  (s8_maddr),
		.s8_caddr  (s8_caddr),
		.sum0      (sum0),
		.sum1      (sum1),
		.mem_rdata (mem_rdata),
		.wr_en     (wr_en),
		.wr_maddr  (wr_maddr),
		.wr_data   (wr_data)
	);

endmodule

`default_nettype wire

/* tb/mlaccel_sva.sv */
// Port rules of the compute unit, checked by assertions bound to the top level.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_sva (
	input logic clock,
	input logic reset,
	input logic cmd_ready,
	input logic busy,
	input logic mem_ren,
	input logic [mlaccel_data_pkg::lanes-1:0] mem_wen
);

	// one port, so a read and a write never share a cycle.
	port_one_user: assert property (@(posedge clock) disable iff (reset)
		!(mem_ren && mem_wen != '0))
		else $error("memory read and write in the same cycle");

	reset_quiet: assert property (@(posedge clock)
		reset |=> (!mem_ren && mem_wen == '0 && !busy))
		else $error("port or busy active right after reset");

	idle_ready: assert property (@(posedge clock) disable iff (reset)
		!busy |-> cmd_ready)
		else $error("cmd_ready low while idle");

endmodule

bind mlaccel_compute mlaccel_sva sva (
	.clock     (clock),
	.reset     (reset),
	.cmd_ready (cmd_ready),
	.busy      (busy),
	.mem_ren   (mem_ren),
	.mem_wen   (mem_wen)
);

`default_nettype wire

/* tb/mlaccel_tb.sv */
// Testbench for the compute unit, with a memory model, a reference model and write checks.
`timescale 1ns/1ps
`default_nettype none

module mlaccel_tb;
	import mlaccel_isa_pkg::*;
	import mlaccel_data_pkg::*;

	localparam int wait_limit = 2000;

	logic clock = 1'b0;
	logic reset;
	logic cmd_valid;
	logic [insn_w-1:0] cmd_insn;
	logic cmd_ready, busy, mem_ren;
	logic [lanes-1:0] mem_wen;
	logic [mem_addr_w-1:0] mem_addr;
	logic [word_w-1:0] mem_wdata, mem_rdata;

	logic [word_w-1:0] mem [0:65535];
	logic [word_w-1:0] rd_pipe [0:mem_latency-1];
	logic [word_w-1:0] rd_pend;

	// reference model state.
	logic [maddr_w-1:0] m_vbp;
	logic [caddr_w-1:0] m_cbp;
	logic [word_w-1:0] m_lo [0:coeff_rows-1];
	logic [word_w-1:0] m_hi [0:coeff_rows-1];
	logic [acc_w-1:0] m_acc0, m_acc1;
	logic [lanes-1:0] exp_wen [$];
	logic [mem_addr_w-1:0] exp_addr [$];
	logic [word_w-1:0] exp_data [$];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int stalls = 0;
	bit timed_out = 1'b0;

	mlaccel_compute UUT (.*);

	always #50 clock = ~clock;

	// read data follows the request by mem_latency cycles.
	always @(negedge clock) begin
		rd_pend <= mem_ren ? mem[mem_addr] : 'x;
		if (!reset && mem_wen != '0) begin
			for (int i = 0; i < lanes; i++)
				if (mem_wen[i])
					mem[mem_addr][i*lane_w +: lane_w] = mem_wdata[i*lane_w +: lane_w];
			check_write();
		end
	end

	always @(posedge clock) begin
		rd_pipe[0] <= rd_pend;
		for (int i = 1; i < mem_latency; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end
	assign mem_rdata = rd_pipe[mem_latency-1];

	task automatic check_write();
		logic ok;
		checks++;
		if (exp_wen.size() == 0) begin
			$display("unexpected memory write at %0t", $time);
			errors++;
		end else begin
			ok = (mem_wen == exp_wen[0]) && (mem_addr == exp_addr[0]);
			for (int i = 0; i < lanes; i++)
				if (exp_wen[0][i] && mem_wdata[i*lane_w +: lane_w] != exp_data[0][i*lane_w +: lane_w])
					ok = 1'b0;
			assert (ok) else begin
				$display("[ERROR] %0t write wen %h addr %h data %h, expected %h %h %h", $time,
					mem_wen, mem_addr, mem_wdata, exp_wen[0], exp_addr[0], exp_data[0]);
				errors++;
			end
			void'(exp_wen.pop_front());
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
	endtask

	function automatic logic [insn_w-1:0] make_insn(int opc, int maddr, int caddr);
		return {maddr[maddr_w-1:0], caddr[caddr_w-1:0], opc[opcode_w-1:0]};
	endfunction

	function automatic int dot8(logic [word_w-1:0] v, logic [word_w-1:0] c);
		int s;
		s = 0;
		for (int i = 0; i < lanes; i++)
			s += $signed(v[i*lane_w +: lane_w]) * $signed(c[i*lane_w +: lane_w]);
		return s;
	endfunction

	function automatic logic [lane_w-1:0] clamp_shift(logic [acc_w-1:0] acc, int sh);
		logic signed [acc_w-1:0] v;
		v = $signed(acc) >>> sh;
		if (v > 127)
			return 8'h7f;
		if (v < -128)
			return 8'h80;
		return v[lane_w-1:0];
	endfunction

	// applies one instruction to the model, in issue order.
	task automatic model_step(logic [insn_w-1:0] insn);
		logic [5:0] opc;
		logic [maddr_w-1:0] ma, va;
		logic [caddr_w-1:0] ca, row;
		logic [word_w-1:0] w;
		logic [lane_w-1:0] b0, b1;
		logic en0, en1;
		logic [lanes-1:0] wen;
		logic [word_w-1:0] wdata;
		int lo;
		opc = insn[5:0];
		ma = insn[31:15];
		ca = insn[14:6];
		case (opc)
			6'd8: m_vbp = ma;
			6'd9: m_vbp = m_vbp + ma;
			6'd14: m_cbp = ca;
			6'd15: m_cbp = m_cbp + ca;
			6'd5: m_lo[ca] = mem[ma[16:1]];
			6'd6: m_hi[ca] = mem[ma[16:1]];
			6'd40, 6'd42: begin
				va = ma + m_vbp;
				w = mem[va[16:1]];
				row = m_cbp + ca;
				if (opc == 6'd42) begin
					m_acc0 = '0;
					m_acc1 = '0;
				end
				m_acc0 = m_acc0 + dot8(w, m_lo[row]);
				m_acc1 = m_acc1 + dot8(w, m_hi[row]);
			end
			6'd28, 6'd29, 6'd30: begin
				w = mem[ma[16:1]];
				if (opc != 6'd30)
					m_acc0 = w[31:0];
				if (opc != 6'd29)
					m_acc1 = w[63:32];
			end
			6'd16, 6'd17, 6'd18, 6'd20, 6'd21, 6'd22: begin
				b0 = clamp_shift(m_acc0, ca);
				b1 = clamp_shift(m_acc1, ca);
				if (opc[2] && b0[7])
					b0 = '0;
				if (opc[2] && b1[7])
					b1 = '0;
				en0 = opc[1:0] != 2'd2;
				en1 = opc[1:0] != 2'd1;
				lo = ma[0];    // an odd address starts one lane up.
				wen = '0;
				wdata = '0;
				wen[lo] = en0;
				wen[lo+1] = en1;
				wdata[lo*lane_w +: lane_w] = b0;
				wdata[(lo+1)*lane_w +: lane_w] = b1;
				exp_wen.push_back(wen);
				exp_addr.push_back(ma[16:1]);
				exp_data.push_back(wdata);
			end
			default: ;    // no-op.
		endcase
	endtask

	// called right after a rising edge, returns after the edge that took the command.
	task automatic issue(logic [insn_w-1:0] insn);
		logic rdy;
		int n;
		model_step(insn);
		cmd_valid <= 1'b1;
		cmd_insn <= insn;
		n = 0;
		do begin
			@(negedge clock);
			rdy = cmd_ready;
			if (!rdy)
				stalls++;
			@(posedge clock);
			n++;
			if (n > wait_limit) begin
				$display("timeout: command was never accepted");
				timed_out = 1'b1;
				end_run();
			end
		end while (!rdy);
	endtask

	task automatic wait_idle();
		int n;
		cmd_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge clock);
			n++;
			if (n > wait_limit) begin
				$display("timeout: unit stayed busy");
				timed_out = 1'b1;
				end_run();
			end
		end while (busy);
		@(negedge clock);    // the last store write falls in the first idle cycle.
		if (exp_wen.size() != 0) begin
			$display("expected writes did not happen: %0d left", exp_wen.size());
			errors += exp_wen.size();
			exp_wen.delete();
			exp_addr.delete();
			exp_data.delete();
		end
		@(posedge clock);
	endtask

	task automatic test_done(string name, int err_before);
		tests++;
		$display("test %0d %s: %s", tests, name, errors == err_before ? "ok" : "FAILED");
	endtask

	task automatic end_run();
		$display("tests %0d, write checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	initial begin
		int e;
		int st;
		int shifts [6];
		shifts = '{0, 4, 8, 16, 31, 2};
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		rd_pend = '0;
		for (int i = 0; i < mem_latency; i++)
			rd_pipe[i] = '0;
		void'($urandom(32'h9270bddd));
		for (int a = 0; a < 65536; a++)
			mem[a] = {16'(a), ~16'(a), 16'(a) ^ 16'h5a5a, 16'(a * 3)};
		for (int a = 0; a < 1024; a++)
			mem[a] = {$urandom, $urandom};
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		// reset state.
		e = errors;
		@(negedge clock);
		assert (!busy && !mem_ren && mem_wen == '0 && cmd_ready) else begin
			$display("[ERROR] %0t outputs not idle after reset", $time);
			errors++;
		end
		@(posedge clock);
		test_done("reset state", e);

		// plain stores, odd addresses and single lanes.
		e = errors;
		mem[10] = {32'hffff_fff0, 32'h0000_0045};
		issue(make_insn(28, 20, 0));
		issue(make_insn(16, 'h10000, 0));
		issue(make_insn(16, 'h10003, 0));
		issue(make_insn(17, 'h10004, 0));
		issue(make_insn(18, 'h10007, 0));
		wait_idle();
		test_done("store lanes", e);

		// saturation over several shifts, with ReLU.
		e = errors;
		mem[20] = {32'hfff0_0000, 32'h0001_2345};
		mem[21] = {32'h0000_01f4, 32'hffff_fed4};
		st = 'h10100;
		for (int k = 0; k < 2; k++) begin
			issue(make_insn(28, 40 + 2 * k, 0));
			foreach (shifts[j]) begin
				issue(make_insn(16, st, shifts[j]));
				issue(make_insn(20, st + 1, shifts[j]));
				st += 2;
			end
			issue(make_insn(21, st, 0));
			issue(make_insn(22, st + 3, 0));
			st += 4;
		end
		wait_idle();
		test_done("saturation and relu", e);

		// dot products over loaded rows.
		e = errors;
		for (int r = 0; r < 4; r++) begin
			issue(make_insn(5, 200 + 4 * r, 10 + r));
			issue(make_insn(6, 202 + 4 * r, 10 + r));
		end
		wait_idle();
		issue(make_insn(14, 0, 8));
		issue(make_insn(15, 0, 2));
		issue(make_insn(8, 400, 0));
		issue(make_insn(9, 6, 0));
		for (int k = 0; k < 3; k++) begin
			issue(make_insn(42, $urandom_range(0, 255), $urandom_range(0, 3)));
			repeat (3)
				issue(make_insn(40, $urandom_range(0, 255), $urandom_range(0, 3)));
			issue(make_insn(16, 'h10200 + 2 * k, 0));
			issue(make_insn(16, 'h10300 + 2 * k, 10 + k));
		end
		wait_idle();
		test_done("dot product", e);

		// back to back traffic that has to hit the interlock.
		e = errors;
		stalls = 0;
		issue(make_insn(28, 60, 0));
		repeat (4)
			issue(make_insn(40, $urandom_range(0, 255), $urandom_range(0, 3)));
		for (int k = 0; k < 40; k++) begin
			case ($urandom_range(0, 2))
				0: issue(make_insn(16 + $urandom_range(0, 2) + 4 * $urandom_range(0, 1),
					'h10400 + $urandom_range(0, 4095), $urandom_range(0, 15)));
				1: issue(make_insn(28 + $urandom_range(0, 2), $urandom_range(0, 1023), 0));
				default: issue(make_insn(40 + 2 * $urandom_range(0, 1),
					$urandom_range(0, 255), $urandom_range(0, 3)));
			endcase
		end
		wait_idle();
		assert (stalls > 0) else begin
			$display("[ERROR] %0t cmd_ready never dropped", $time);
			errors++;
		end
		test_done("interlock", e);

		end_run();
	end

endmodule

`default_nettype wire

/* flist.f */
design/mlaccel_isa_pkg.sv
design/mlaccel_data_pkg.sv
design/mlaccel_control.sv
design/mlaccel_mem_port.sv
design/mlaccel_coeff_store.sv
design/mlaccel_mac_array.sv
design/mlaccel_accum.sv
design/mlaccel_compute.sv
tb/mlaccel_sva.sv
tb/mlaccel_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mlaccel_tb
RTL_TOP   ?= mlaccel_compute
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
